// File: common/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Command opcodes are the ASCII letters the host sends
  typedef enum logic [7:0] {
    OP_WRITE = 8'h57,
    OP_READ  = 8'h52
  } cmd_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_DATA,
    ST_RD_ADDR,
    ST_RD_SEND
  } ctrl_state_t;

  // One received byte, valid is a single-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic       en;
    logic [7:0] addr;
    logic [7:0] data;
  } reg_wr_t;

  // Start may only be raised while the transmitter is idle
  typedef struct packed {
    logic       start;
    logic [7:0] data;
  } tx_req_t;

endpackage

// File: uart/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
  parameter int CLOCK_FREQ = 10_000_000,
  parameter int BAUD_RATE  = 1_000_000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  output uart_cmd_pkg::rx_byte_t rx_byte
);

  localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLOCKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLOCKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [2:0]       rx_pipe;
  logic             rx_in;
  logic             rx_fall;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_q;
  logic             valid_q;

  // Two sync stages, the third stage only feeds the edge detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_pipe <= '1;
    end else begin
      rx_pipe <= {rx_pipe[1:0], rx};
    end
  end

  assign rx_in   = rx_pipe[1];
  // A frame starts only on a falling edge, so a line held low
  // after a bad stop bit does not retrigger
  assign rx_fall = rx_pipe[2] & ~rx_pipe[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rx_fall) begin
            // The detect cycle already counts toward the half bit
            clk_cnt <= CNT_W'(1);
            state   <= RX_START;
          end
        end
        RX_START: begin
          if (rx_in) begin
            state <= RX_IDLE;
          end else if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            shift_q <= {rx_in, shift_q[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt == BIT_END) begin
            // Low stop bit means a framing error, byte is dropped
            valid_q <= rx_in;
            clk_cnt <= '0;
            state   <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  assign rx_byte = '{valid: valid_q, data: shift_q};

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
  parameter int CLOCK_FREQ = 10_000_000,
  parameter int BAUD_RATE  = 1_000_000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  uart_cmd_pkg::tx_req_t tx_req,
  output logic                  tx_busy,
  output logic                  tx
);

  localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLOCKS_PER_BIT - 1);

  // Bit 0 of the frame is always the level on the line
  logic [9:0]       frame_q;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic             busy_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_q <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (tx_req.start) begin
        // Stop, data LSB first, start
        frame_q <= {1'b1, tx_req.data, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
        busy_q  <= 1'b1;
      end
    end else if (clk_cnt == BIT_END) begin
      clk_cnt <= '0;
      // Ones shift in behind, so the line idles high after the stop bit
      frame_q <= {1'b1, frame_q[9:1]};
      if (bit_cnt == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign tx      = frame_q[0];
  assign tx_busy = busy_q;

endmodule

// File: source/reg_bank.sv
`timescale 1ns/10ps

module reg_bank #(
  parameter int NUM_REGS = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  uart_cmd_pkg::reg_wr_t reg_wr,
  input  logic [7:0]            rd_addr,
  output logic [7:0]            rd_data,
  output logic [NUM_REGS*8-1:0] regs
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  localparam logic [8:0] ADDR_LIMIT = 9'(NUM_REGS);

  logic [NUM_REGS-1:0][7:0] regs_q;
  logic                     wr_in_range;
  logic                     rd_in_range;

  assign wr_in_range = {1'b0, reg_wr.addr} < ADDR_LIMIT;
  assign rd_in_range = {1'b0, rd_addr} < ADDR_LIMIT;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs_q <= '0;
    end else if (reg_wr.en && wr_in_range) begin
      regs_q[reg_wr.addr[IDX_W-1:0]] <= reg_wr.data;
    end
  end

  // Out of range reads return zero
  assign rd_data = rd_in_range ? regs_q[rd_addr[IDX_W-1:0]] : 8'h00;
  assign regs    = regs_q;

endmodule

// File: source/cmd_ctrl.sv
`timescale 1ns/10ps

module cmd_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_cmd_pkg::rx_byte_t rx_byte,
  output uart_cmd_pkg::reg_wr_t  reg_wr,
  output logic [7:0]             rd_addr,
  input  logic [7:0]             rd_data,
  output uart_cmd_pkg::tx_req_t  tx_req,
  input  logic                   tx_busy
);

  uart_cmd_pkg::ctrl_state_t state;
  uart_cmd_pkg::ctrl_state_t state_next;
  logic [7:0]                addr_q;

  always_comb begin
    state_next = state;
    case (state)
      uart_cmd_pkg::ST_IDLE: begin
        if (rx_byte.valid) begin
          case (rx_byte.data)
            uart_cmd_pkg::OP_WRITE: state_next = uart_cmd_pkg::ST_WR_ADDR;
            uart_cmd_pkg::OP_READ:  state_next = uart_cmd_pkg::ST_RD_ADDR;
            // Anything else is not a command
            default:                state_next = uart_cmd_pkg::ST_IDLE;
          endcase
        end
      end
      uart_cmd_pkg::ST_WR_ADDR: begin
        if (rx_byte.valid) begin
          state_next = uart_cmd_pkg::ST_WR_DATA;
        end
      end
      uart_cmd_pkg::ST_WR_DATA: begin
        if (rx_byte.valid) begin
          state_next = uart_cmd_pkg::ST_IDLE;
        end
      end
      uart_cmd_pkg::ST_RD_ADDR: begin
        if (rx_byte.valid) begin
          state_next = uart_cmd_pkg::ST_RD_SEND;
        end
      end
      uart_cmd_pkg::ST_RD_SEND: begin
        // Bytes arriving here are ignored until the reply goes out
        if (!tx_busy) begin
          state_next = uart_cmd_pkg::ST_IDLE;
        end
      end
      default: state_next = uart_cmd_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= uart_cmd_pkg::ST_IDLE;
      addr_q <= '0;
    end else begin
      state <= state_next;
      if (rx_byte.valid && (state == uart_cmd_pkg::ST_WR_ADDR ||
                            state == uart_cmd_pkg::ST_RD_ADDR)) begin
        addr_q <= rx_byte.data;
      end
    end
  end

  // Write strobe rides on the data byte, so the bank updates on the next edge
  always_comb begin
    reg_wr.en   = (state == uart_cmd_pkg::ST_WR_DATA) && rx_byte.valid;
    reg_wr.addr = addr_q;
    reg_wr.data = rx_byte.data;
  end

  assign rd_addr = addr_q;

  // Range check is left to the bank, reply carries whatever it returns
  always_comb begin
    tx_req.start = (state == uart_cmd_pkg::ST_RD_SEND) && !tx_busy;
    tx_req.data  = rd_data;
  end

endmodule

// File: source/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top #(
  parameter int CLOCK_FREQ = 10_000_000,
  parameter int BAUD_RATE  = 1_000_000,
  parameter int NUM_REGS   = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  output logic                  tx,
  output logic [NUM_REGS*8-1:0] regs
);

  uart_cmd_pkg::rx_byte_t rx_byte;
  uart_cmd_pkg::reg_wr_t  reg_wr;
  uart_cmd_pkg::tx_req_t  tx_req;
  logic [7:0]             rd_addr;
  logic [7:0]             rd_data;
  logic                   tx_busy;

  uart_rx #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) uart_rx_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_byte(rx_byte)
  );

  cmd_ctrl cmd_ctrl_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx_byte(rx_byte),
    .reg_wr (reg_wr),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .tx_req (tx_req),
    .tx_busy(tx_busy)
  );

  reg_bank #(
    .NUM_REGS(NUM_REGS)
  ) reg_bank_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .reg_wr (reg_wr),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .regs   (regs)
  );

  uart_tx #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) uart_tx_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .tx_req (tx_req),
    .tx_busy(tx_busy),
    .tx     (tx)
  );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// File: verification/uart_cmd_tb.sv
`timescale 1ns/10ps

module uart_cmd_tb;

  localparam int CLOCK_FREQ     = 10_000_000;
  localparam int BAUD_RATE      = 1_000_000;
  localparam int NUM_REGS       = 4;
  localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int REGS_W         = NUM_REGS * 8;
  localparam int BIT_NS         = CLOCKS_PER_BIT * 4;
  // Upper bound on frames sent or waited for over all tests
  localparam int TOTAL_FRAMES   = 230;
  localparam int WATCHDOG_NS    = TOTAL_FRAMES * 10 * BIT_NS * 2;
  localparam logic [7:0] CMD_WRITE = 8'h57;
  localparam logic [7:0] CMD_READ  = 8'h52;

  logic              clk;
  logic              rst_n;
  logic              rx;
  logic              tx;
  logic [REGS_W-1:0] regs;
  logic [7:0]        model_regs [NUM_REGS];
  logic [7:0]        reply_q [$];
  logic [7:0]        patterns [12] = '{8'h00, 8'hFF, 8'h55, 8'hAA, 8'h01, 8'h02,
                                       8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80};
  int unsigned       seed_ret;
  int                mismatches = 0;
  int                other_errors = 0;

  tb_clock #(.PERIOD_NS(4.0)) tb_clock_inst (.clk(clk));

  uart_cmd_top #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE),
    .NUM_REGS  (NUM_REGS)
  ) uart_cmd_top_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .rx   (rx),
    .tx   (tx),
    .regs (regs)
  );

  task automatic check_value(input logic [REGS_W-1:0] actual,
                             input logic [REGS_W-1:0] expected, input string what);
    if (actual !== expected) begin
      mismatches++;
      $display("FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  function automatic logic [7:0] model_read(input logic [7:0] addr);
    if (int'(addr) < NUM_REGS) return model_regs[int'(addr)];
    return 8'h00;
  endfunction

  function automatic logic [REGS_W-1:0] model_packed();
    logic [REGS_W-1:0] packed_val;
    for (int i = 0; i < NUM_REGS; i++) packed_val[i*8 +: 8] = model_regs[i];
    return packed_val;
  endfunction

  // Called right after a rising edge and holds the level for a number of cycles
  task automatic drive_level(input logic level, input int cycles);
    rx <= level;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic idle_bits(input int bits);
    drive_level(1'b1, bits * CLOCKS_PER_BIT);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop_level);
    drive_level(1'b0, CLOCKS_PER_BIT);
    for (int i = 0; i < 8; i++) drive_level(data[i], CLOCKS_PER_BIT);
    drive_level(stop_level, CLOCKS_PER_BIT);
  endtask

  task automatic write_cmd(input logic [7:0] addr, input logic [7:0] data);
    send_frame(CMD_WRITE, 1'b1);
    send_frame(addr, 1'b1);
    send_frame(data, 1'b1);
    // Out of range writes leave the model untouched
    if (int'(addr) < NUM_REGS) model_regs[int'(addr)] = data;
  endtask

  task automatic read_cmd(input logic [7:0] addr);
    int         waited;
    logic [7:0] got;
    send_frame(CMD_READ, 1'b1);
    send_frame(addr, 1'b1);
    waited = 0;
    while (reply_q.size() == 0 && waited < 15 * CLOCKS_PER_BIT) begin
      @(posedge clk);
      waited++;
    end
    if (reply_q.size() == 0) begin
      other_errors++;
      $display("ERROR: no reply byte arrived for the read of address %0d", addr);
    end else begin
      got = reply_q.pop_front();
      check_value(REGS_W'(got), REGS_W'(model_read(addr)),
                  $sformatf("reply for read of address %0d", addr));
    end
    // Reply stop bit must end before the host sends again
    repeat (CLOCKS_PER_BIT) @(posedge clk);
  endtask

  task automatic check_regs(input string what);
    @(negedge clk);
    check_value(regs, model_packed(), what);
    @(posedge clk);
  endtask

  task automatic check_no_reply(input string what);
    if (reply_q.size() != 0) begin
      other_errors++;
      $display("ERROR: %0d unexpected reply byte(s) %s", reply_q.size(), what);
      reply_q.delete();
    end
  endtask

  // Decodes reply frames on tx at bit centers
  initial begin : tx_monitor
    logic [7:0] data;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      repeat (CLOCKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        other_errors++;
        $display("ERROR: start bit on tx did not stay low at %0d ns", $time);
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (CLOCKS_PER_BIT) @(negedge clk);
          data[i] = tx;
        end
        repeat (CLOCKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1) begin
          other_errors++;
          $display("ERROR: stop bit on tx was low at %0d ns", $time);
        end
        reply_q.push_back(data);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] addr;
    logic [7:0] data;
    int         tx_low_cycles;
    rst_n <= 1'b0;
    rx    <= 1'b1;
    seed_ret = $urandom(96);
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = 8'h00;
    tx_low_cycles = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Idle for three frame times after reset
    repeat (30 * CLOCKS_PER_BIT) begin
      @(negedge clk);
      if (tx !== 1'b1) tx_low_cycles++;
    end
    @(posedge clk);
    check_value(REGS_W'(tx_low_cycles), '0, "cycles with tx low after reset");
    check_regs("regs after reset");
    check_no_reply("after reset");

    // Random writes with some addresses out of range and then reads of every address
    for (int n = 0; n < 40; n++) begin
      addr = 8'($urandom_range(7, 0));
      data = 8'($urandom);
      write_cmd(addr, data);
      check_regs($sformatf("regs after write of 0x%0h to address %0d", data, addr));
    end
    for (int a = 0; a < 8; a++) read_cmd(8'(a));

    // Back-to-back frames checked once per group of NUM_REGS writes
    for (int i = 0; i < 12; i++) begin
      write_cmd(8'(i % NUM_REGS), patterns[i]);
      if (i % NUM_REGS == NUM_REGS - 1) check_regs("regs after back-to-back writes");
    end

    // Quarter-bit glitch on rx shortly before a write
    idle_bits(2);
    drive_level(1'b0, CLOCKS_PER_BIT / 4);
    idle_bits(3);
    addr = 8'($urandom_range(NUM_REGS - 1, 0));
    data = 8'($urandom);
    write_cmd(addr, data);
    check_regs("regs after false start bit and the following write");
    check_no_reply("after false start bit");
    read_cmd(addr);

    // An opcode with a low stop bit must vanish
    write_cmd(8'd1, 8'($urandom));
    send_frame(CMD_WRITE, 1'b0);
    idle_bits(2);
    write_cmd(8'd2, 8'($urandom));
    check_regs("regs after dropped frame");
    read_cmd(8'd1);
    read_cmd(8'd2);

    // Junk bytes in idle
    for (int n = 0; n < 10; n++) begin
      do begin
        data = 8'($urandom);
      end while (data == CMD_WRITE || data == CMD_READ);
      send_frame(data, 1'b1);
    end
    idle_bits(12);
    check_regs("regs after non-opcode bytes");
    check_no_reply("after non-opcode bytes");
    read_cmd(8'd0);

    idle_bits(12);
    check_no_reply("at end of run");
    $display("Run finished with %0d value mismatches and %0d other errors",
             mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
common/uart_cmd_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
source/reg_bank.sv
source/cmd_ctrl.sv
source/uart_cmd_top.sv
verification/tb_clock.sv
verification/uart_cmd_tb.sv

// File: Makefile
TOP := uart_cmd_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f flist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module uart_cmd_top -f flist.f

clean:
	rm -rf obj_dir
